//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_saturnBusGlue -f sim.f -o simv --Mdir obj_dir
	./obj_dir/simv | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- busActivityMonitor.sv
`timescale 1ns/100ps

module busActivityMonitor #(
	parameter saturnPkg::cpuAddrT HOOK_ADDR     = 25'h00012B0,
	parameter saturnPkg::cdAddrT  CD_WATCH_ADDR = 18'h3AC0C
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	mainBusIf.sink               mainMon,
	cdBusIf.sink                 cdMon,
	output saturnPkg::dbgCountT  dbgWaitCnt,
	output logic                 dbgHook,
	output saturnPkg::dbgCountT  dbgCdCnt
);

	logic mainIdle;
	logic hookHit;
	logic cdWrite;
	logic cdWrOld;
	logic cdWatchHit;

	// No read strobe and every byte lane masked
	assign mainIdle = mainMon.rdN & (&mainMon.dqm);
	assign hookHit  = !mainMon.rdN && !mainMon.cs3N && (mainMon.addr == HOOK_ADDR);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dbgWaitCnt <= '0;
			dbgHook    <= 1'b0;
		end else if (mainMon.ceR) begin
			if (mainIdle) begin
				dbgWaitCnt <= '0;
			end else begin
				dbgWaitCnt <= dbgWaitCnt + 1'b1;
			end
			if (hookHit) begin
				dbgHook <= 1'b1;
			end
		end
	end

	assign cdWrite    = !cdMon.wrlN || !cdMon.wrhN;
	assign cdWatchHit = !cdMon.cs1N && (cdMon.cdAddr == CD_WATCH_ADDR);

	// Count once per write burst, on its first enabled cycle
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cdWrOld  <= 1'b0;
			dbgCdCnt <= '0;
		end else if (cdMon.shCeR) begin
			cdWrOld <= cdWrite;
			if (cdWrite && !cdWrOld && cdWatchHit) begin
				dbgCdCnt <= dbgCdCnt + 1'b1;
			end
		end
	end

	hookSticky: assert property (@(posedge CLK) disable iff (!RST_N) dbgHook |=> dbgHook)
		else $error("dbgHook dropped without reset");

endmodule

//--- busInterfaces.sv
`timescale 1ns/100ps

// Main-bus events seen by the debug monitor
interface mainBusIf;
	logic               ceR;
	saturnPkg::cpuAddrT addr;
	saturnPkg::dqmT     dqm;
	logic               rdN;
	logic               cs3N;

	modport source (
		output ceR,
		output addr,
		output dqm,
		output rdN,
		output cs3N
	);

	modport sink (
		input ceR,
		input addr,
		input dqm,
		input rdN,
		input cs3N
	);
endinterface

// CD processor write events
interface cdBusIf;
	logic              shCeR;
	saturnPkg::cdAddrT cdAddr;
	logic              cs1N;
	logic              wrlN;
	logic              wrhN;

	modport source (
		output shCeR,
		output cdAddr,
		output cs1N,
		output wrlN,
		output wrhN
	);

	modport sink (
		input shCeR,
		input cdAddr,
		input cs1N,
		input wrlN,
		input wrhN
	);
endinterface

//--- cdBufferBridge.sv
`timescale 1ns/100ps

module cdBufferBridge (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              shCeR,
	input  saturnPkg::cdAddrT sa,
	input  saturnPkg::cdDataT sdo,
	input  logic              cs1N,
	input  logic              wrlN,
	input  logic              wrhN,
	input  logic              rdN,
	input  saturnPkg::cdDataT bridgeRdData,
	input  saturnPkg::cdDataT cdRamQ,
	input  logic              cdRamRdy,
	output saturnPkg::cdDataT sdi,
	output logic              swaitN,
	output saturnPkg::cdAddrT cdRamA,
	output saturnPkg::cdDataT cdRamD,
	output logic              cdRamCs,
	output logic [1:0]        cdRamWe,
	output logic              cdRamRd,
	cdBusIf.source            mon
);

	// Buffer RAM takes active high strobes
	assign cdRamA  = sa;
	assign cdRamD  = sdo;
	assign cdRamCs = ~cs1N;
	assign cdRamWe = ~{wrhN, wrlN};
	assign cdRamRd = ~rdN;

	// CS1 reads come from the buffer, all else from the host bridge
	assign sdi    = !cs1N ? cdRamQ : bridgeRdData;
	assign swaitN = cdRamRdy;

	assign mon.shCeR  = shCeR;
	assign mon.cdAddr = sa;
	assign mon.cs1N   = cs1N;
	assign mon.wrlN   = wrlN;
	assign mon.wrhN   = wrhN;

	rdWeExclusive: assert property (@(posedge CLK) disable iff (!RST_N)
		!(cdRamRd && (|cdRamWe)))
		else $error("CD buffer read and write strobes high together");

endmodule

//--- clockEnableGen.sv
`timescale 1ns/100ps

module clockEnableGen #(
	parameter int SMPC_DIV = 7
) (
	input  logic CLK,
	input  logic RST_N,
	input  logic ce,
	input  logic pause,
	input  logic cdCe,
	output logic ceR,
	output logic ceF,
	output logic smpcCe,
	output logic smpcResN,
	output logic shCeR,
	output logic shCeF
);

	localparam int CNT_W = (SMPC_DIV > 1) ? $clog2(SMPC_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SMPC_DIV - 1);

	logic             mclk;
	logic             shClk;
	logic [CNT_W-1:0] divCnt;

	// Main clock phase, frozen while paused
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mclk <= 1'b0;
		end else if (ce && !pause) begin
			mclk <= ~mclk;
		end
	end

	assign ceR = mclk & ~pause;
	assign ceF = ~mclk & ~pause;

	// CD processor phase runs on its own enable
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			shClk <= 1'b0;
		end else if (cdCe) begin
			shClk <= ~shClk;
		end
	end

	assign shCeR = shClk & cdCe;
	assign shCeF = ~shClk & cdCe;

	// Slow SMPC enable; its reset lifts on the first enable seen
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			divCnt   <= '0;
			smpcCe   <= 1'b0;
			smpcResN <= 1'b0;
		end else if (ceR) begin
			if (divCnt == CNT_LAST) begin
				divCnt <= '0;
				smpcCe <= 1'b1;
			end else begin
				divCnt <= divCnt + 1'b1;
				smpcCe <= 1'b0;
			end
			if (smpcCe) begin
				smpcResN <= 1'b1;
			end
		end
	end

	ceExclusive: assert property (@(posedge CLK) disable iff (!RST_N) !(ceR && ceF))
		else $error("ceR and ceF high in the same cycle");

endmodule

//--- mainBusRouter.sv
`timescale 1ns/100ps

module mainBusRouter (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                ceR,
	input  saturnPkg::cpuAddrT  addr,
	input  saturnPkg::cpuDataT  wrData,
	input  saturnPkg::dqmT      dqm,
	input  logic                rdN,
	input  logic                cs0N,
	input  logic                cs3N,
	input  logic                scuWaitN,
	input  saturnPkg::cpuDataT  memRdData,
	input  saturnPkg::smpcDataT smpcRdData,
	input  saturnPkg::cpuDataT  scuRdData,
	input  logic                memWaitN,
	output saturnPkg::cpuDataT  rdData,
	output logic                cpuWaitN,
	output logic                romCsN,
	output logic                ramlCsN,
	output logic                ramhCsN,
	output logic                smpcCsN,
	output saturnPkg::cpuAddrT  memAddr,
	output saturnPkg::cpuDataT  memWrData,
	mainBusIf.source            mon
);

	logic romSel;
	logic ramlSel;
	logic ramhSel;
	logic smpcSel;
	logic memSel;

	function automatic logic inWindow(
		input saturnPkg::cpuAddrT a,
		input saturnPkg::cpuAddrT base,
		input saturnPkg::cpuAddrT limit
	);
		return (a >= base) && (a <= limit);
	endfunction

	// CS0 space split by the console memory map
	assign romSel  = !cs0N && inWindow(addr, saturnPkg::ROM_BASE, saturnPkg::ROM_LIMIT);
	assign smpcSel = !cs0N && inWindow(addr, saturnPkg::SMPC_BASE, saturnPkg::SMPC_LIMIT);
	assign ramlSel = !cs0N && inWindow(addr, saturnPkg::RAML_BASE, saturnPkg::RAML_LIMIT);
	assign ramhSel = !cs3N;
	assign memSel  = romSel | ramlSel | ramhSel;

	assign romCsN  = ~romSel;
	assign ramlCsN = ~ramlSel;
	assign ramhCsN = ~ramhSel;
	assign smpcCsN = ~smpcSel;

	assign memAddr   = addr;
	assign memWrData = wrData;

	// SMPC is a byte port, so its data shows on every lane
	assign rdData = memSel  ? memRdData :
	                smpcSel ? {4{smpcRdData}} :
	                scuRdData;

	// Memory wait only counts when a memory is addressed
	assign cpuWaitN = scuWaitN & (memWaitN | ~memSel);

	assign mon.ceR  = ceR;
	assign mon.addr = addr;
	assign mon.dqm  = dqm;
	assign mon.rdN  = rdN;
	assign mon.cs3N = cs3N;

	selOneHot: assert property (@(posedge CLK) disable iff (!RST_N)
		$onehot0({romSel, ramlSel, ramhSel, smpcSel}))
		else $error("more than one main-bus select active");

endmodule

//--- saturnBusGlue.sv
`timescale 1ns/100ps

module saturnBusGlue #(
	parameter int                 SMPC_DIV      = 7,
	parameter saturnPkg::cpuAddrT HOOK_ADDR     = 25'h00012B0,
	parameter saturnPkg::cdAddrT  CD_WATCH_ADDR = 18'h3AC0C
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ce,
	input  logic                 pause,
	input  logic                 cdCe,
	output logic                 ceR,
	output logic                 ceF,
	output logic                 smpcCe,
	output logic                 smpcResN,
	output logic                 shCeR,
	output logic                 shCeF,

	input  saturnPkg::cpuAddrT   addr,
	input  saturnPkg::cpuDataT   wrData,
	input  saturnPkg::dqmT       dqm,
	input  logic                 rdN,
	input  logic                 cs0N,
	input  logic                 cs3N,
	input  logic                 scuWaitN,
	input  saturnPkg::cpuDataT   memRdData,
	input  saturnPkg::smpcDataT  smpcRdData,
	input  saturnPkg::cpuDataT   scuRdData,
	input  logic                 memWaitN,
	output saturnPkg::cpuDataT   rdData,
	output logic                 cpuWaitN,
	output logic                 romCsN,
	output logic                 ramlCsN,
	output logic                 ramhCsN,
	output logic                 smpcCsN,
	output saturnPkg::cpuAddrT   memAddr,
	output saturnPkg::cpuDataT   memWrData,

	// CD processor side; cdRdN is the CD read strobe
	input  saturnPkg::cdAddrT    sa,
	input  saturnPkg::cdDataT    sdo,
	input  logic                 cs1N,
	input  logic                 wrlN,
	input  logic                 wrhN,
	input  logic                 cdRdN,
	input  saturnPkg::cdDataT    bridgeRdData,
	input  saturnPkg::cdDataT    cdRamQ,
	input  logic                 cdRamRdy,
	output saturnPkg::cdDataT    sdi,
	output logic                 swaitN,
	output saturnPkg::cdAddrT    cdRamA,
	output saturnPkg::cdDataT    cdRamD,
	output logic                 cdRamCs,
	output logic [1:0]           cdRamWe,
	output logic                 cdRamRd,

	output saturnPkg::dbgCountT  dbgWaitCnt,
	output logic                 dbgHook,
	output saturnPkg::dbgCountT  dbgCdCnt
);

	mainBusIf mainBus ();
	cdBusIf   cdBus ();

	clockEnableGen #(
		.SMPC_DIV(SMPC_DIV)
	) clkEn_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ce(ce),
		.pause(pause),
		.cdCe(cdCe),
		.ceR(ceR),
		.ceF(ceF),
		.smpcCe(smpcCe),
		.smpcResN(smpcResN),
		.shCeR(shCeR),
		.shCeF(shCeF)
	);

	mainBusRouter router_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceR(ceR),
		.addr(addr),
		.wrData(wrData),
		.dqm(dqm),
		.rdN(rdN),
		.cs0N(cs0N),
		.cs3N(cs3N),
		.scuWaitN(scuWaitN),
		.memRdData(memRdData),
		.smpcRdData(smpcRdData),
		.scuRdData(scuRdData),
		.memWaitN(memWaitN),
		.rdData(rdData),
		.cpuWaitN(cpuWaitN),
		.romCsN(romCsN),
		.ramlCsN(ramlCsN),
		.ramhCsN(ramhCsN),
		.smpcCsN(smpcCsN),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.mon(mainBus.source)
	);

	cdBufferBridge cdBridge_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.shCeR(shCeR),
		.sa(sa),
		.sdo(sdo),
		.cs1N(cs1N),
		.wrlN(wrlN),
		.wrhN(wrhN),
		.rdN(cdRdN),
		.bridgeRdData(bridgeRdData),
		.cdRamQ(cdRamQ),
		.cdRamRdy(cdRamRdy),
		.sdi(sdi),
		.swaitN(swaitN),
		.cdRamA(cdRamA),
		.cdRamD(cdRamD),
		.cdRamCs(cdRamCs),
		.cdRamWe(cdRamWe),
		.cdRamRd(cdRamRd),
		.mon(cdBus.source)
	);

	busActivityMonitor #(
		.HOOK_ADDR(HOOK_ADDR),
		.CD_WATCH_ADDR(CD_WATCH_ADDR)
	) monitor_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.mainMon(mainBus.sink),
		.cdMon(cdBus.sink),
		.dbgWaitCnt(dbgWaitCnt),
		.dbgHook(dbgHook),
		.dbgCdCnt(dbgCdCnt)
	);

endmodule

//--- saturnPkg.sv
package saturnPkg;

	// Main processor bus
	typedef logic [24:0] cpuAddrT;
	typedef logic [31:0] cpuDataT;

	// Active low, one bit per byte lane
	typedef logic [3:0] dqmT;

	typedef logic [7:0] smpcDataT;

	// Word address into the CD buffer RAM, taken from A[18:1]
	typedef logic [17:0] cdAddrT;
	typedef logic [15:0] cdDataT;

	typedef logic [7:0] dbgCountT;

	// Windows decoded inside chip select 0
	localparam cpuAddrT ROM_BASE   = 25'h0000000;
	localparam cpuAddrT ROM_LIMIT  = 25'h007FFFF;

	localparam cpuAddrT SMPC_BASE  = 25'h0100000;
	localparam cpuAddrT SMPC_LIMIT = 25'h017FFFF;

	localparam cpuAddrT RAML_BASE  = 25'h0200000;
	localparam cpuAddrT RAML_LIMIT = 25'h02FFFFF;

	// High RAM is the whole of chip select 3

endpackage

//--- sim.f
saturnPkg.sv
busInterfaces.sv
clockEnableGen.sv
mainBusRouter.sv
cdBufferBridge.sv
busActivityMonitor.sv
saturnBusGlue.sv
tb_saturnBusGlue.sv

//--- tb_saturnBusGlue.sv
`timescale 1ns/100ps

module tb_saturnBusGlue;

	localparam int SMPC_DIV = 7;
	localparam saturnPkg::cpuAddrT HOOK_ADDR = 25'h00012B0;
	localparam saturnPkg::cdAddrT CD_WATCH_ADDR = 18'h3AC0C;
	localparam int NUM_DECODE = 24;
	localparam int NUM_CD = 16;
	localparam int TEST_CYCLES = 4 + 34 + 6 * SMPC_DIV + 2 + 4 * NUM_DECODE + 50 + NUM_CD + 60;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * 100;

	logic CLK = 1'b0;
	logic RST_N;
	logic ce, pause, cdCe, ceR, ceF, smpcCe, smpcResN, shCeR, shCeF;
	saturnPkg::cpuAddrT addr, memAddr;
	saturnPkg::cpuDataT wrData, memRdData, scuRdData, rdData, memWrData;
	saturnPkg::dqmT dqm;
	saturnPkg::smpcDataT smpcRdData;
	logic rdN, cs0N, cs3N, scuWaitN, memWaitN, cpuWaitN;
	logic romCsN, ramlCsN, ramhCsN, smpcCsN;
	saturnPkg::cdAddrT sa, cdRamA;
	saturnPkg::cdDataT sdo, bridgeRdData, cdRamQ, sdi, cdRamD;
	logic cs1N, wrlN, wrhN, cdRdN, cdRamRdy, swaitN, cdRamCs, cdRamRd;
	logic [1:0] cdRamWe;
	saturnPkg::dbgCountT dbgWaitCnt, dbgCdCnt;
	logic dbgHook;

	logic [31:0] seed = 32'h98cc;
	string testName = "reset";
	int exclErrs = 0;
	int pauseErrs = 0;
	int altErrs = 0;
	int cdEnErrs = 0;
	int stickyErrs = 0;
	int refErrs = 0;
	int valueErrs = 0;

	// Reference state, updated from the enables seen at each falling edge
	int refCnt;
	logic refSmpc, refResN, refHook;
	saturnPkg::dbgCountT refWait;
	saturnPkg::dbgCountT cdExp = '0;

	saturnBusGlue #(
		.SMPC_DIV(SMPC_DIV),
		.HOOK_ADDR(HOOK_ADDR),
		.CD_WATCH_ADDR(CD_WATCH_ADDR)
	) dut_i (.*);

	always #50 CLK = ~CLK;

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic inRange(input saturnPkg::cpuAddrT a, lo, hi);
		return (a >= lo) && (a <= hi);
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual, inout int errCount);
		assert (expected === actual) else begin
			errCount++;
			$display("mismatch %s %s: expected %0h, actual %0h",
				testName, name, expected, actual);
		end
	endtask

	task automatic step();
		@(posedge CLK);
		#1;
	endtask

	task automatic idleMain();
		addr = '0;
		wrData = '0;
		dqm = 4'hF;
		rdN = 1'b1;
		cs0N = 1'b1;
		cs3N = 1'b1;
		scuWaitN = 1'b1;
		memWaitN = 1'b1;
	endtask

	task automatic idleCd();
		cs1N = 1'b1;
		wrlN = 1'b1;
		wrhN = 1'b1;
		cdRdN = 1'b1;
	endtask

	task automatic checkDecode();
		logic romExp, smpcExp, ramlExp, ramhExp, memExp;
		logic [31:0] dataExp;
		romExp = !cs0N && inRange(addr, saturnPkg::ROM_BASE, saturnPkg::ROM_LIMIT);
		smpcExp = !cs0N && inRange(addr, saturnPkg::SMPC_BASE, saturnPkg::SMPC_LIMIT);
		ramlExp = !cs0N && inRange(addr, saturnPkg::RAML_BASE, saturnPkg::RAML_LIMIT);
		ramhExp = !cs3N;
		memExp = romExp || ramlExp || ramhExp;
		if (memExp) begin
			dataExp = memRdData;
		end else if (smpcExp) begin
			dataExp = {4{smpcRdData}};
		end else begin
			dataExp = scuRdData;
		end
		checkValue("romCsN", 32'(!romExp), 32'(romCsN), valueErrs);
		checkValue("smpcCsN", 32'(!smpcExp), 32'(smpcCsN), valueErrs);
		checkValue("ramlCsN", 32'(!ramlExp), 32'(ramlCsN), valueErrs);
		checkValue("ramhCsN", 32'(!ramhExp), 32'(ramhCsN), valueErrs);
		checkValue("rdData", dataExp, rdData, valueErrs);
		checkValue("cpuWaitN", 32'(scuWaitN && (memWaitN || !memExp)), 32'(cpuWaitN), valueErrs);
		checkValue("memAddr", 32'(addr), 32'(memAddr), valueErrs);
		checkValue("memWrData", wrData, memWrData, valueErrs);
	endtask

	task automatic checkCd();
		checkValue("cdRamCs", 32'(!cs1N), 32'(cdRamCs), valueErrs);
		checkValue("cdRamWe", 32'({!wrhN, !wrlN}), 32'(cdRamWe), valueErrs);
		checkValue("cdRamRd", 32'(!cdRdN), 32'(cdRamRd), valueErrs);
		checkValue("sdi", 32'(cs1N ? bridgeRdData : cdRamQ), 32'(sdi), valueErrs);
		checkValue("swaitN", 32'(cdRamRdy), 32'(swaitN), valueErrs);
		checkValue("cdRamA", 32'(sa), 32'(cdRamA), valueErrs);
		checkValue("cdRamD", 32'(sdo), 32'(cdRamD), valueErrs);
	endtask

	// One write burst, then a gap long enough for the burst to end on an shCeR
	task automatic cdBurst(input saturnPkg::cdAddrT a, input logic csN,
		input logic [1:0] strobes, input int len);
		sa = a;
		cs1N = csN;
		{wrhN, wrlN} = ~strobes;
		sdo = 16'(nextRand());
		if (a == CD_WATCH_ADDR && !csN) begin
			cdExp = cdExp + 8'd1;
		end
		repeat (len) step();
		idleCd();
		repeat (4) step();
		checkValue("dbgCdCnt", 32'(cdExp), 32'(dbgCdCnt), valueErrs);
	endtask

	always @(negedge CLK) begin
		if (!RST_N) begin
			refCnt = 0;
			refSmpc = 1'b0;
			refResN = 1'b0;
			refHook = 1'b0;
			refWait = '0;
		end else begin
			checkValue("smpcCe", 32'(refSmpc), 32'(smpcCe), refErrs);
			checkValue("smpcResN", 32'(refResN), 32'(smpcResN), refErrs);
			checkValue("dbgWaitCnt", 32'(refWait), 32'(dbgWaitCnt), refErrs);
			checkValue("dbgHook", 32'(refHook), 32'(dbgHook), refErrs);
			if (ceR) begin
				if (refSmpc) begin
					refResN = 1'b1;
				end
				if (refCnt == SMPC_DIV - 1) begin
					refCnt = 0;
					refSmpc = 1'b1;
				end else begin
					refCnt++;
					refSmpc = 1'b0;
				end
				if (rdN && dqm == 4'hF) begin
					refWait = '0;
				end else begin
					refWait = refWait + 8'd1;
				end
				if (!rdN && !cs3N && addr == HOOK_ADDR) begin
					refHook = 1'b1;
				end
			end
		end
	end

	enableExcl: assert property (@(posedge CLK) disable iff (!RST_N) !(ceR && ceF))
		else begin
			exclErrs++;
			$display("ceR and ceF were high together in test %s", testName);
		end

	pauseQuiet: assert property (@(posedge CLK) disable iff (!RST_N) pause |-> !ceR && !ceF)
		else begin
			pauseErrs++;
			$display("an enable was high while pause was held in test %s", testName);
		end

	// Each running cycle hands over from one phase to the other
	enableAlt: assert property (@(posedge CLK) disable iff (!RST_N)
		(ce && !pause) |=> (pause || (ceR == $past(ceF))))
		else begin
			altErrs++;
			$display("ceR and ceF did not alternate in test %s", testName);
		end

	// CD phases exist only while cdCe is high
	cdEnableLevel: assert property (@(posedge CLK) disable iff (!RST_N)
		cdCe ? (shCeR != shCeF) : (!shCeR && !shCeF))
		else begin
			cdEnErrs++;
			$display("shCeR and shCeF did not follow cdCe in test %s", testName);
		end

	cdEnableAlt: assert property (@(posedge CLK) disable iff (!RST_N)
		cdCe |=> (!cdCe || (shCeR == $past(shCeF))))
		else begin
			cdEnErrs++;
			$display("shCeR and shCeF did not alternate in test %s", testName);
		end

	stickyFlags: assert property (@(posedge CLK) disable iff (!RST_N)
		!$fell(smpcResN) && !$fell(dbgHook))
		else begin
			stickyErrs++;
			$display("smpcResN or dbgHook fell without reset in test %s", testName);
		end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		int total;
		RST_N = 1'b0;
		ce = 1'b1;
		pause = 1'b0;
		cdCe = 1'b1;
		idleMain();
		idleCd();
		memRdData = '0;
		scuRdData = '0;
		smpcRdData = '0;
		sa = '0;
		sdo = '0;
		bridgeRdData = '0;
		cdRamQ = '0;
		cdRamRdy = 1'b1;
		repeat (3) step();
		RST_N = 1'b1;

		testName = "enables";
		repeat (10) step();
		pause = 1'b1;
		repeat (6) step();
		pause = 1'b0;
		repeat (10) step();
		cdCe = 1'b0;
		repeat (4) step();
		cdCe = 1'b1;
		repeat (4) step();

		testName = "smpc enable";
		repeat (6 * SMPC_DIV) step();

		testName = "idle decode";
		@(negedge CLK);
		checkDecode();
		step();

		testName = "main decode";
		for (int i = 0; i < NUM_DECODE; i++) begin
			r = nextRand();
			case (r[1:0])
				2'd0: addr = saturnPkg::ROM_BASE + 25'(r[30:12]);
				2'd1: addr = saturnPkg::SMPC_BASE + 25'(r[30:12]);
				2'd2: addr = saturnPkg::RAML_BASE + 25'(r[31:12]);
				default: addr = 25'(nextRand());
			endcase
			cs0N = (i % 5 == 4);
			cs3N = !cs0N;
			// Keeps high RAM reads off the hook address
			if (!cs3N) begin
				addr[24] = 1'b1;
			end
			rdN = 1'b0;
			dqm = 4'hF;
			wrData = nextRand();
			memRdData = nextRand();
			scuRdData = nextRand();
			smpcRdData = 8'(nextRand());
			for (int w = 0; w < 4; w++) begin
				scuWaitN = w[1];
				memWaitN = w[0];
				@(negedge CLK);
				checkDecode();
				step();
			end
		end

		testName = "wait counter";
		idleMain();
		repeat (3) step();
		addr = 25'h0200040;
		cs0N = 1'b0;
		rdN = 1'b0;
		repeat (12) step();
		pause = 1'b1;
		repeat (3) step();
		pause = 1'b0;
		repeat (6) step();
		idleMain();
		repeat (4) step();
		checkValue("dbgWaitCnt", 32'd0, 32'(dbgWaitCnt), valueErrs);

		testName = "boot hook";
		checkValue("dbgHook", 32'd0, 32'(dbgHook), valueErrs);
		addr = HOOK_ADDR;
		cs0N = 1'b0;
		rdN = 1'b0;
		repeat (4) step();
		idleMain();
		addr = HOOK_ADDR;
		cs3N = 1'b0;
		dqm = 4'h0;
		repeat (4) step();
		idleMain();
		step();
		checkValue("dbgHook", 32'd0, 32'(dbgHook), valueErrs);
		addr = HOOK_ADDR;
		cs3N = 1'b0;
		rdN = 1'b0;
		repeat (4) step();
		idleMain();
		repeat (2) step();
		checkValue("dbgHook", 32'd1, 32'(dbgHook), valueErrs);

		testName = "cd strobes";
		for (int i = 0; i < NUM_CD; i++) begin
			r = nextRand();
			r2 = nextRand();
			sa = 18'(nextRand());
			if (sa == CD_WATCH_ADDR) begin
				sa = sa ^ 18'h1;
			end
			sdo = r[15:0];
			cdRamQ = r[31:16];
			bridgeRdData = r2[31:16];
			cs1N = r2[0];
			cdRdN = r2[1];
			cdRamRdy = r2[2];
			{wrhN, wrlN} = cdRdN ? r2[4:3] : 2'b11;
			@(negedge CLK);
			checkCd();
			step();
		end

		testName = "cd watch";
		idleCd();
		repeat (4) step();
		cdBurst(CD_WATCH_ADDR, 1'b0, 2'b01, 2);
		cdBurst(CD_WATCH_ADDR, 1'b0, 2'b11, 8);
		cdBurst(CD_WATCH_ADDR ^ 18'h1, 1'b0, 2'b11, 4);
		cdBurst(CD_WATCH_ADDR, 1'b1, 2'b11, 4);
		cdBurst(CD_WATCH_ADDR, 1'b0, 2'b10, 3);

		total = exclErrs + pauseErrs + altErrs + cdEnErrs + stickyErrs + refErrs + valueErrs;
		$display("Errors: excl %0d pause %0d alt %0d cdEn %0d sticky %0d ref %0d value %0d",
			exclErrs, pauseErrs, altErrs, cdEnErrs, stickyErrs, refErrs, valueErrs);
		if (total == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
